/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // architectural widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // an instruction address
    typedef logic [XLEN-1:0] pc_t;

    // an instruction word
    typedef logic [ILEN-1:0] insn_t;

    // one instruction handed to decode, also the fetch buffer payload
    typedef struct packed {
        pc_t   pc;
        insn_t insn;
    } fetch_rsp_t;

    // one outstanding memory request, tagged with the path it was fetched on
    typedef struct packed {
        pc_t  pc;
        logic epoch;
    } inflight_t;

    // pc after reset
    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

    // sequential fetch stride, no compressed instructions
    localparam pc_t PC_STEP = 64'd4;

    // request slots the memory grants after reset
    localparam int IMEM_CREDITS = 4;

    // items decode can absorb after reset
    localparam int DEC_CREDITS = 2;

    // buffer capacity, also bounds in-flight plus buffered entries
    localparam int FBUF_DEPTH = 4;
    localparam int FBUF_PTR_W = $clog2(FBUF_DEPTH);

    // occupancy and credit counters, wide enough to hold FBUF_DEPTH
    localparam int CNT_W = 3;

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none

module sync_fifo import fetch_pkg::*; #(
    parameter type T = logic
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             flush,
    input  wire logic             push,
    input  wire T                 push_data,
    input  wire logic             pop,
    output T                      pop_data,
    output logic                  empty,
    output logic [CNT_W-1:0]      count
);

    T                      mem [FBUF_DEPTH];
    logic [FBUF_PTR_W-1:0] wr_ptr;
    logic [FBUF_PTR_W-1:0] rd_ptr;
    logic                  full;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(FBUF_DEPTH));
    assign pop_data = mem[rd_ptr];

    // storage, written only on an accepted push
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // producers must respect the occupancy bound
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push && !flush) |-> (!full || pop)
    );

    // consumers only pop what is there
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pop && !flush) |-> !empty
    );

endmodule

`default_nettype wire

/* verilog/pc_unit.sv */
`default_nettype none

module pc_unit import fetch_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic issue,
    input  wire logic redirect_valid,
    input  wire pc_t  redirect_pc,
    input  wire logic hold_start,
    input  wire logic hold_done,
    output pc_t       pc,
    output logic      epoch,
    output logic      fetch_allow
);

    typedef enum logic {
        RUN  = 1'b0,
        HOLD = 1'b1
    } hold_state_e;

    hold_state_e state;
    hold_state_e state_nxt;

    // fetch pc, redirect wins over sequential advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (issue) begin
            pc <= pc + PC_STEP;
        end
    end

    // one epoch per path, flips on every redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch <= 1'b0;
        end else if (redirect_valid) begin
            epoch <= ~epoch;
        end
    end

    // long mul/div hold
    always_comb begin
        state_nxt = state;
        case (state)
            RUN: begin
                if (hold_start) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (hold_done) begin
                    state_nxt = RUN;
                end
            end
            default: begin
                state_nxt = RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // blocked already on the edge that samples hold_start
    assign fetch_allow = (state == RUN) && !hold_start;

    // issue logic lives in fetch_issue and must honour the hold
    a_no_issue_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hold_start || state == HOLD) |-> !issue
    );

endmodule

`default_nettype wire

/* verilog/fetch_issue.sv */
`default_nettype none

module fetch_issue import fetch_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire pc_t              pc,
    input  wire logic             epoch,
    input  wire logic             fetch_allow,
    input  wire logic             redirect_valid,
    output logic                  issue,
    output logic                  imem_req_valid,
    output pc_t                   imem_req_addr,
    input  wire logic             imem_credit,
    input  wire logic             imem_rsp_valid,
    input  wire insn_t            imem_rsp_insn,
    input  wire logic [CNT_W-1:0] buf_count,
    output logic                  buf_push,
    output fetch_rsp_t            buf_data
);

    logic [CNT_W-1:0] credit_cnt;
    logic [CNT_W-1:0] infl_count;
    logic [CNT_W-1:0] stale_cnt;
    logic [CNT_W:0]   occupancy;
    logic             infl_empty;
    inflight_t        infl_new;
    inflight_t        infl_head;
    logic             rsp_keep;

    assign occupancy = infl_count + buf_count;

    assign issue = fetch_allow && (credit_cnt != '0) && (occupancy < FBUF_DEPTH)
                   && !redirect_valid;

    assign infl_new = '{pc: pc, epoch: epoch};

    // pcs of outstanding requests, memory answers in order
    sync_fifo #(
        .T (inflight_t)
    ) u_inflight (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (1'b0),
        .push      (issue),
        .push_data (infl_new),
        .pop       (imem_rsp_valid),
        .pop_data  (infl_head),
        .empty     (infl_empty),
        .count     (infl_count)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_req_valid <= 1'b0;
            credit_cnt     <= CNT_W'(IMEM_CREDITS);
        end else begin
            imem_req_valid <= issue;
            credit_cnt     <= credit_cnt - CNT_W'(issue) + CNT_W'(imem_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            imem_req_addr <= pc;
        end
    end

    // a single epoch bit aliases after two redirects with requests still out,
    // so also count the entries that were in flight at the last redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stale_cnt <= '0;
        end else if (redirect_valid) begin
            stale_cnt <= infl_count - CNT_W'(imem_rsp_valid);
        end else if (imem_rsp_valid && stale_cnt != '0) begin
            stale_cnt <= stale_cnt - 1'b1;
        end
    end

    assign rsp_keep = (infl_head.epoch == epoch) && (stale_cnt == '0);

    // nothing enters the buffer on the flush edge
    assign buf_push = imem_rsp_valid && rsp_keep && !redirect_valid;
    assign buf_data = '{pc: infl_head.pc, insn: imem_rsp_insn};

    // memory never gives back more slots than it granted
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= CNT_W'(IMEM_CREDITS)
    );

    // a response always has a matching request
    a_rsp_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_rsp_valid |-> !infl_empty
    );

endmodule

`default_nettype wire

/* verilog/fetch_buffer.sv */
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       redirect_valid,
    input  wire logic       buf_push,
    input  wire fetch_rsp_t buf_data,
    output logic [CNT_W-1:0] buf_count,
    output logic            out_valid,
    output fetch_rsp_t      out_rsp,
    input  wire logic       out_credit
);

    logic [CNT_W-1:0] dec_credits;
    logic             buf_empty;
    logic             buf_pop;
    fetch_rsp_t       buf_head;

    sync_fifo #(
        .T (fetch_rsp_t)
    ) u_fbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect_valid),
        .push      (buf_push),
        .push_data (buf_data),
        .pop       (buf_pop),
        .pop_data  (buf_head),
        .empty     (buf_empty),
        .count     (buf_count)
    );

    // send one per cycle while decode has room
    assign buf_pop = !buf_empty && (dec_credits != '0) && !redirect_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            dec_credits <= CNT_W'(DEC_CREDITS);
        end else begin
            out_valid   <= buf_pop;
            dec_credits <= dec_credits - CNT_W'(buf_pop) + CNT_W'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (buf_pop) begin
            out_rsp <= buf_head;
        end
    end

    // decode returns no more than it was given
    a_dec_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_credits <= CNT_W'(DEC_CREDITS)
    );

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,

    // instruction memory
    output logic       imem_req_valid,
    output pc_t        imem_req_addr,
    input  wire logic  imem_credit,
    input  wire logic  imem_rsp_valid,
    input  wire insn_t imem_rsp_insn,

    // decode
    output logic       out_valid,
    output fetch_rsp_t out_rsp,
    input  wire logic  out_credit,

    // execute
    input  wire logic  redirect_valid,
    input  wire pc_t   redirect_pc,
    input  wire logic  hold_start,
    input  wire logic  hold_done
);

    pc_t              pc;
    logic             epoch;
    logic             fetch_allow;
    logic             issue;
    logic             buf_push;
    fetch_rsp_t       buf_data;
    logic [CNT_W-1:0] buf_count;

    pc_unit u_pc_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (issue),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold_start     (hold_start),
        .hold_done      (hold_done),
        .pc             (pc),
        .epoch          (epoch),
        .fetch_allow    (fetch_allow)
    );

    fetch_issue u_fetch_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc             (pc),
        .epoch          (epoch),
        .fetch_allow    (fetch_allow),
        .redirect_valid (redirect_valid),
        .issue          (issue),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_insn  (imem_rsp_insn),
        .buf_count      (buf_count),
        .buf_push       (buf_push),
        .buf_data       (buf_data)
    );

    fetch_buffer u_fetch_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .buf_push       (buf_push),
        .buf_data       (buf_data),
        .buf_count      (buf_count),
        .out_valid      (out_valid),
        .out_rsp        (out_rsp),
        .out_credit     (out_credit)
    );

endmodule

`default_nettype wire

/* dv/imem_model.sv */
`default_nettype none

module imem_model import fetch_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic req_valid,
    input  wire pc_t  req_addr,
    output logic      rsp_valid,
    output insn_t     rsp_insn,
    output logic      credit
);

    // instruction word is the low pc bits scrambled with a fixed key
    localparam insn_t INSN_KEY = 32'h1357_9bdf;

    pc_t addr_q[$];
    int  due_q[$];
    int  cyc;
    int  last_due;

    initial begin
        rsp_valid = 1'b0;
        rsp_insn  = '0;
        credit    = 1'b0;
        cyc       = 0;
        last_due  = 0;
    end

    // outputs change 1 unit after the edge like the rest of the stimulus
    always @(posedge clk) begin
        bit  in_reset;
        pc_t addr;
        int  due;
        in_reset = !rst_n;
        #1;
        rsp_valid = 1'b0;
        credit    = 1'b0;
        if (in_reset) begin
            addr_q.delete();
            due_q.delete();
            cyc      = 0;
            last_due = 0;
        end else begin
            cyc++;
            // never due before the previous answer
            if (req_valid) begin
                due = cyc + int'($urandom_range(6, 1));
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(req_addr);
                due_q.push_back(due);
            end
            if (due_q.size() != 0 && due_q[0] <= cyc) begin
                addr = addr_q.pop_front();
                due_q.delete(0);
                rsp_valid = 1'b1;
                rsp_insn  = addr[31:0] ^ INSN_KEY;
                // slot freed as the answer goes out
                credit    = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/fetch_tb.sv */
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int    STIM_CYCLES    = 4000;
    localparam int    TIMEOUT_CYCLES = 20000;
    localparam int    DRAIN_ITEMS    = 32;
    localparam int    MIN_DELIVERED  = 500;
    localparam insn_t INSN_KEY       = 32'h1357_9bdf;

    logic       clk;
    logic       rst_n;
    logic       imem_req_valid;
    pc_t        imem_req_addr;
    logic       imem_credit;
    logic       imem_rsp_valid;
    insn_t      imem_rsp_insn;
    logic       out_valid;
    fetch_rsp_t out_rsp;
    logic       out_credit;
    logic       redirect_valid;
    pc_t        redirect_pc;
    logic       hold_start;
    logic       hold_done;

    // reference model state
    pc_t exp_pc;
    int  cycles;
    int  delivered;
    int  ret_owed;
    int  mem_out;
    int  dec_out;
    int  hold_left;
    int  stall_left;
    bit  holding;
    bit  quiet_prev;
    int  err_rsp;
    int  err_count;
    int  err_quiet;
    int  err_other;

    fetch_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_insn  (imem_rsp_insn),
        .out_valid      (out_valid),
        .out_rsp        (out_rsp),
        .out_credit     (out_credit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold_start     (hold_start),
        .hold_done      (hold_done)
    );

    imem_model u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (imem_req_valid),
        .req_addr  (imem_req_addr),
        .rsp_valid (imem_rsp_valid),
        .rsp_insn  (imem_rsp_insn),
        .credit    (imem_credit)
    );

    always #4 clk = ~clk;

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            err_rsp++;
            $display("Fail %0t: decode got pc %h insn %h, expected pc %h insn %h",
                     $time, got.pc, got.insn, exp.pc, exp.insn);
        end
    endtask

    task automatic check_count(input logic [CNT_W-1:0] count,
                               input logic [CNT_W-1:0] bound, input string what);
        if (count > bound) begin
            err_count++;
            $display("Fail %0t: %s outstanding %0d above bound %0d",
                     $time, what, count, bound);
        end
    endtask

    task automatic check_quiet(input logic req, input bit quiet);
        if (req && quiet) begin
            err_quiet++;
            $display("memory request sent while fetch was held, at time %0t", $time);
        end
    endtask

    // one cycle of execute and decode stimulus
    // with active low no new redirect, hold or stall begins
    task automatic drive_cycle(input bit active);
        redirect_valid = 1'b0;
        hold_start     = 1'b0;
        hold_done      = 1'b0;
        out_credit     = 1'b0;
        if (active && $urandom_range(99) < 3) begin
            redirect_valid = 1'b1;
            redirect_pc    = {$urandom, $urandom} & ~64'h3;
        end
        if (hold_left != 0) begin
            hold_left--;
            hold_done = (hold_left == 0);
        end else if (active && $urandom_range(99) < 2) begin
            hold_start = 1'b1;
            hold_left  = $urandom_range(12, 1);
        end
        // long decode stalls now and then
        if (stall_left != 0) begin
            stall_left--;
        end else if (active && $urandom_range(199) == 0) begin
            stall_left = $urandom_range(80, 20);
        end
        if (stall_left == 0 && ret_owed > 0 && $urandom_range(3) != 0) begin
            out_credit = 1'b1;
            ret_owed--;
        end
    endtask

    // sampled on the edge before the DUT updates
    always @(posedge clk) begin
        fetch_rsp_t exp_rsp;
        bit         win;
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end else if (rst_n) begin
            if (out_valid) begin
                exp_rsp.pc   = exp_pc;
                exp_rsp.insn = exp_pc[31:0] ^ INSN_KEY;
                check_rsp(out_rsp, exp_rsp);
                exp_pc = exp_pc + 64'd4;
                delivered++;
                ret_owed++;
            end
            // new path starts at the target
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
            mem_out = mem_out + int'(imem_req_valid) - int'(imem_credit);
            dec_out = dec_out + int'(out_valid) - int'(out_credit);
            check_count(CNT_W'(mem_out), CNT_W'(IMEM_CREDITS), "memory requests");
            check_count(CNT_W'(dec_out), CNT_W'(DEC_CREDITS), "decode items");
            // request seen now was issued at the previous edge
            check_quiet(imem_req_valid, quiet_prev);
            win = hold_start || holding;
            if (hold_start) begin
                holding = 1'b1;
            end
            if (hold_done) begin
                holding = 1'b0;
            end
            quiet_prev = win;
        end
    end

    initial begin
        int mark;
        void'($urandom(32'h5a2c));
        clk = 1'b0;
        rst_n = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        hold_start = 1'b0;
        hold_done = 1'b0;
        out_credit = 1'b0;
        exp_pc = RESET_PC;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(posedge clk);
            #1;
            drive_cycle(1'b1);
        end
        // fetch must keep flowing once stalls and holds end
        mark = delivered;
        while (delivered < mark + DRAIN_ITEMS) begin
            @(posedge clk);
            #1;
            drive_cycle(1'b0);
        end
        if (delivered < MIN_DELIVERED) begin
            err_other++;
            $display("only %0d instructions reached decode", delivered);
        end
        $display("errors: rsp %0d, count %0d, hold %0d, other %0d (delivered %0d)",
                 err_rsp, err_count, err_quiet, err_other, delivered);
        if (err_rsp + err_count + err_quiet + err_other == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_top.f */
verilog/fetch_pkg.sv
verilog/sync_fifo.sv
verilog/pc_unit.sv
verilog/fetch_issue.sv
verilog/fetch_buffer.sv
verilog/fetch_top.sv
dv/imem_model.sv
dv/fetch_tb.sv

/* Makefile */
SIM = obj_dir/fetch_sim

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
		-f fetch_top.f -o fetch_sim

run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
